// ==== adc5g_ctrl.f ====
design/adc5g_ctrl_pkg.sv
design/adc_reset_gen.sv
design/adc3wire_engine.sv
design/adc_reg_port.sv
design/adc5g_ctrl.sv
testbench/adc5g_ctrl_tb.sv

// ==== design/adc3wire_engine.sv ====
// ADC 3-wire serial engine
`timescale 1ns/1ps
`default_nettype none

module adc3wire_engine (
  input  wire                                   OPB_Clk,
  input  wire                                   reset,
  input  wire                                   cfg_req,
  input  wire [adc5g_ctrl_pkg::CFG_ADDR_W-1:0]  cfg_addr,
  input  wire [adc5g_ctrl_pkg::CFG_DATA_W-1:0]  cfg_data,
  input  wire                                   sdata_in,
  output logic                                  cfg_ack,
  output logic [adc5g_ctrl_pkg::CFG_DATA_W-1:0] rd_data,
  output logic                                  sclk,
  output logic                                  sdata,
  output logic                                  modepin
);
  import adc5g_ctrl_pkg::*;

  cfg_state_t            state;
  logic [SCLK_DIV_W-1:0] div_cnt;
  logic [PROG_W-1:0]     bit_cnt;
  logic [FRAME_W-1:0]    tx_shift;
  logic [CFG_DATA_W-1:0] rx_shift;
  logic                  writing;
  logic                  falling;
  logic                  prerise;
  logic                  midhigh;

  assign falling = div_cnt == '0;
  assign prerise = div_cnt == SCLK_PRERISE;
  assign midhigh = div_cnt == SCLK_MIDHIGH;

  // divider only runs while a frame is active
  always_ff @(posedge OPB_Clk) begin
    if (reset || state == IDLE) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      state   <= IDLE;
      cfg_ack <= 1'b0;
      writing <= 1'b0;
      bit_cnt <= '0;
    end else begin
      if (cfg_ack && !cfg_req) begin
        cfg_ack <= 1'b0;
      end
      case (state)
        IDLE: begin
          if (cfg_req && !cfg_ack) begin
            state    <= CLKWAIT;
            writing  <= cfg_addr[CFG_ADDR_W-1]; // bit 7 set means write
            tx_shift <= {cfg_addr, cfg_data};
            rx_shift <= '0;
          end
        end
        CLKWAIT: begin
          if (falling) begin
            state   <= ADDR;
            bit_cnt <= '0;
          end
        end
        ADDR: begin
          if (falling) begin
            tx_shift <= tx_shift << 1;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == PROG_W'(CFG_ADDR_W - 1)) begin
              state <= writing ? WRITE : READWAIT;
            end
          end
        end
        WRITE: begin
          if (falling) begin
            tx_shift <= tx_shift << 1;
            bit_cnt  <= bit_cnt + 1'b1;
          end
          if (midhigh && bit_cnt == PROG_W'(FRAME_W - 1)) begin
            state <= ALMOST_DONE;
          end
        end
        READWAIT: begin
          if (falling) begin
            state <= READ; // one silent sclk period
          end
        end
        READ: begin
          if (prerise) begin
            rx_shift <= {rx_shift[CFG_DATA_W-2:0], sdata_in};
            bit_cnt  <= bit_cnt + 1'b1;
          end
          if (midhigh && bit_cnt == PROG_W'(FRAME_W)) begin
            state <= ALMOST_DONE;
          end
        end
        ALMOST_DONE: begin
          if (prerise) begin
            state <= FINISH;
          end
        end
        FINISH: begin
          if (falling) begin
            state   <= IDLE;
            cfg_ack <= 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign rd_data = rx_shift;
  assign sdata   = tx_shift[FRAME_W-1]; // msb first
  assign modepin = !(state inside {ADDR, WRITE, READWAIT, READ});
  assign sclk    = div_cnt[SCLK_DIV_W-1] && !(state inside {READWAIT, FINISH});

  a_ack_from_finish: assert property (@(posedge OPB_Clk) disable iff (reset)
    $rose(cfg_ack) |-> $past(state) == FINISH)
    else $error("cfg_ack rose outside FINISH");

  a_idle_quiet: assert property (@(posedge OPB_Clk) disable iff (reset)
    state == IDLE |-> !sclk)
    else $error("sclk running while idle");

endmodule

`default_nettype wire

// ==== design/adc5g_ctrl.sv ====
// ADC5G configuration controller
`timescale 1ns/1ps
`default_nettype none

module adc5g_ctrl (
  input  wire                                  OPB_Clk,
  input  wire                                  reset,
  input  wire                                  req,
  input  wire                                  we,
  input  wire [adc5g_ctrl_pkg::REG_IDX_W-1:0]  idx,
  input  wire [adc5g_ctrl_pkg::DATA_W-1:0]     wdata,
  input  wire                                  dcm_locked,
  input  wire                                  adc_sdata_in,
  output logic                                 ack,
  output logic [adc5g_ctrl_pkg::DATA_W-1:0]    rdata,
  output logic                                 adc_sclk,
  output logic                                 adc_sdata,
  output logic                                 adc_modepin,
  output logic                                 adc_reset,
  output logic                                 adc_spi_rst
);
  import adc5g_ctrl_pkg::*;

  logic                  rst_req;
  logic                  cfg_req;
  logic                  cfg_ack;
  logic [CFG_ADDR_W-1:0] cfg_addr;
  logic [CFG_DATA_W-1:0] cfg_data;
  logic [CFG_DATA_W-1:0] rd_data;

  assign adc_spi_rst = 1'b1; // spi reset unused, held inactive

  adc_reg_port u_reg_port (
    .OPB_Clk    (OPB_Clk),
    .reset      (reset),
    .req        (req),
    .we         (we),
    .idx        (idx),
    .wdata      (wdata),
    .dcm_locked (dcm_locked),
    .cfg_ack    (cfg_ack),
    .rd_data    (rd_data),
    .adc_reset  (adc_reset),
    .ack        (ack),
    .rdata      (rdata),
    .rst_req    (rst_req),
    .cfg_req    (cfg_req),
    .cfg_addr   (cfg_addr),
    .cfg_data   (cfg_data)
  );

  adc3wire_engine u_engine (
    .OPB_Clk  (OPB_Clk),
    .reset    (reset),
    .cfg_req  (cfg_req),
    .cfg_addr (cfg_addr),
    .cfg_data (cfg_data),
    .sdata_in (adc_sdata_in),
    .cfg_ack  (cfg_ack),
    .rd_data  (rd_data),
    .sclk     (adc_sclk),
    .sdata    (adc_sdata),
    .modepin  (adc_modepin)
  );

  adc_reset_gen u_reset_gen (
    .OPB_Clk   (OPB_Clk),
    .reset     (reset),
    .rst_req   (rst_req),
    .adc_reset (adc_reset)
  );

endmodule

`default_nettype wire

// ==== design/adc5g_ctrl_pkg.sv ====
// ADC5G controller definitions
`default_nettype none

package adc5g_ctrl_pkg;

  // host register port
  localparam int DATA_W    = 32;
  localparam int REG_IDX_W = 3;

  localparam logic [REG_IDX_W-1:0] REG_CTRL   = 3'd0;
  localparam logic [REG_IDX_W-1:0] REG_CONFIG = 3'd1;

  // serial frame layout, address then data
  localparam int CFG_ADDR_W = 8;
  localparam int CFG_DATA_W = 16;
  localparam int FRAME_W    = CFG_ADDR_W + CFG_DATA_W;
  localparam int PROG_W     = $clog2(FRAME_W + 1); // bit counter, holds FRAME_W

  // dcm unlock counter
  localparam int CNT_W = 16;

  // sclk period is 2**SCLK_DIV_W OPB_Clk cycles
  localparam int SCLK_DIV_W = 5;

  localparam logic [SCLK_DIV_W-1:0] SCLK_PRERISE = 5'd15; // read sample point
  localparam logic [SCLK_DIV_W-1:0] SCLK_MIDHIGH = 5'd24; // frame may end here

  // adc reset pulse
  localparam int RST_LENGTH = 16;
  localparam int RST_CNT_W  = $clog2(RST_LENGTH + 1);

  // 3-wire engine states
  typedef enum logic [2:0] {
    IDLE,
    CLKWAIT,
    ADDR,
    WRITE,
    READWAIT,
    READ,
    ALMOST_DONE,
    FINISH
  } cfg_state_t;

endpackage

`default_nettype wire

// ==== design/adc_reg_port.sv ====
// ADC host register port
`timescale 1ns/1ps
`default_nettype none

module adc_reg_port (
  input  wire                                   OPB_Clk,
  input  wire                                   reset,
  input  wire                                   req,
  input  wire                                   we,
  input  wire [adc5g_ctrl_pkg::REG_IDX_W-1:0]   idx,
  input  wire [adc5g_ctrl_pkg::DATA_W-1:0]      wdata,
  input  wire                                   dcm_locked,
  input  wire                                   cfg_ack,
  input  wire [adc5g_ctrl_pkg::CFG_DATA_W-1:0]  rd_data,
  input  wire                                   adc_reset,
  output logic                                  ack,
  output logic [adc5g_ctrl_pkg::DATA_W-1:0]     rdata,
  output logic                                  rst_req,
  output logic                                  cfg_req,
  output logic [adc5g_ctrl_pkg::CFG_ADDR_W-1:0] cfg_addr,
  output logic [adc5g_ctrl_pkg::CFG_DATA_W-1:0] cfg_data
);
  import adc5g_ctrl_pkg::*;

  logic [CNT_W-1:0]      unlock_cnt;
  logic [CFG_DATA_W-1:0] last_rd;
  logic                  cfg_done;
  logic                  accept;

  assign cfg_done = !cfg_req && !cfg_ack; // nothing in flight

  // a CONFIG write waits here until the engine is free
  assign accept = req && !ack && !(we && idx == REG_CONFIG && !cfg_done);

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      ack      <= 1'b0;
      rdata    <= '0;
      rst_req  <= 1'b0;
      cfg_req  <= 1'b0;
      cfg_addr <= '0;
      cfg_data <= '0;
      last_rd  <= '0;
    end else begin
      rst_req <= 1'b0;
      if (!req) begin
        ack <= 1'b0; // second half of the host handshake
      end
      if (cfg_req && cfg_ack) begin
        cfg_req <= 1'b0;
        last_rd <= rd_data;
      end
      if (accept) begin
        ack <= 1'b1;
        case (idx)
          REG_CTRL: begin
            rdata <= {{(DATA_W - CNT_W - 1){1'b0}}, adc_reset, unlock_cnt};
            if (we) begin
              rst_req <= wdata[0];
            end
          end
          REG_CONFIG: begin
            rdata <= {last_rd, cfg_addr, {(DATA_W - CFG_DATA_W - CFG_ADDR_W - 1){1'b0}},
                      cfg_done};
            if (we) begin
              cfg_data <= wdata[CFG_DATA_W-1:0];
              cfg_addr <= wdata[CFG_DATA_W +: CFG_ADDR_W];
              cfg_req  <= wdata[DATA_W-1]; // start bit
            end
          end
          default: begin
            rdata <= '0;
          end
        endcase
      end
    end
  end

  // cycles with the sampling dcm unlocked, wraps
  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      unlock_cnt <= '0;
    end else if (!dcm_locked) begin
      unlock_cnt <= unlock_cnt + 1'b1;
    end
  end

  a_ack_after_req: assert property (@(posedge OPB_Clk) disable iff (reset)
    ack |-> $past(req))
    else $error("ack without a pending req");

  a_cfg_req_held: assert property (@(posedge OPB_Clk) disable iff (reset)
    $fell(cfg_req) |-> $past(cfg_ack))
    else $error("cfg_req dropped before cfg_ack");

endmodule

`default_nettype wire

// ==== design/adc_reset_gen.sv ====
// ADC reset pulse timer
`timescale 1ns/1ps
`default_nettype none

module adc_reset_gen (
  input  wire  OPB_Clk,
  input  wire  reset,
  input  wire  rst_req,
  output logic adc_reset
);
  import adc5g_ctrl_pkg::*;

  logic [RST_CNT_W-1:0] rst_cnt;

  // reloads on system reset or a host request, a new request restarts it
  always_ff @(posedge OPB_Clk) begin
    if (reset || rst_req) begin
      rst_cnt <= RST_CNT_W'(RST_LENGTH);
    end else if (rst_cnt != '0) begin
      rst_cnt <= rst_cnt - 1'b1;
    end
  end

  assign adc_reset = rst_cnt != '0;

  a_full_pulse: assert property (@(posedge OPB_Clk) disable iff (reset)
    $fell(adc_reset) |-> $past(rst_cnt) == RST_CNT_W'(1))
    else $error("adc_reset cut short");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the adc5g_ctrl simulation with Verilator
verilator --binary --timing --assert --top-module adc5g_ctrl_tb \
  -f adc5g_ctrl.f -o adc5g_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/adc5g_sim > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Everything OK" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"

// ==== testbench/adc5g_ctrl_tb.sv ====
// ADC5G controller testbench
`timescale 1ns/1ps
`default_nettype none

module adc5g_ctrl_tb;
  import adc5g_ctrl_pkg::*;

  localparam int MAX_CYCLES = 10000; // about six frames plus margin

  logic        OPB_Clk, reset, req, we, dcm_locked, adc_sdata_in;
  logic [2:0]  idx;
  logic [31:0] wdata, rdata, rd_word, seed;
  logic        ack, adc_sclk, adc_sdata, adc_modepin, adc_reset, adc_spi_rst;
  logic        sclk_q, mode_q, rd_mode;
  logic [23:0] frame_bits;
  logic [15:0] rd_value;
  logic [7:0]  addr;
  logic [15:0] data;
  int          rises, frames_done, frames_before, cycles, run_len, last_run, low_cycles, n;

  adc5g_ctrl uut (.OPB_Clk(OPB_Clk), .reset(reset), .req(req), .we(we), .idx(idx),
    .wdata(wdata), .dcm_locked(dcm_locked), .adc_sdata_in(adc_sdata_in), .ack(ack),
    .rdata(rdata), .adc_sclk(adc_sclk), .adc_sdata(adc_sdata), .adc_modepin(adc_modepin),
    .adc_reset(adc_reset), .adc_spi_rst(adc_spi_rst));

  initial begin
    OPB_Clk = 1'b0;
    forever #5 OPB_Clk = ~OPB_Clk;
  end

  task automatic stop_run;
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp === got) else begin
      $display("ERR %0t %s exp %0h got %0h", $time, name, exp, got);
      stop_run();
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // four-phase host cycle, result is rdata at ack
  task automatic host_access(input logic wr, input logic [2:0] index, input logic [31:0] value,
                             output logic [31:0] result);
    @(posedge OPB_Clk);
    req <= 1'b1;
    we <= wr;
    idx <= index;
    wdata <= value;
    @(negedge OPB_Clk);
    while (!ack) @(negedge OPB_Clk);
    result = rdata;
    @(posedge OPB_Clk);
    req <= 1'b0;
    @(negedge OPB_Clk);
    while (ack) @(negedge OPB_Clk);
  endtask

  task automatic wait_done(output logic [31:0] result);
    do host_access(1'b0, REG_CONFIG, 32'h0, result); while (!result[0]);
  endtask

  // serial adc model, edges seen through OPB_Clk sampling
  always @(posedge OPB_Clk) begin
    sclk_q <= adc_sclk;
    mode_q <= adc_modepin;
    if (mode_q && !adc_modepin) begin
      rises <= 0; // frame start
    end else if (!adc_modepin && adc_sclk && !sclk_q) begin
      frame_bits <= {frame_bits[22:0], adc_sdata};
      rises <= rises + 1;
      if (rises == 0) rd_mode <= !adc_sdata;
    end
    if (!mode_q && adc_modepin) frames_done <= frames_done + 1;
    if (!adc_sclk && sclk_q && rd_mode && rises >= 8 && rises < 24)
      adc_sdata_in <= rd_value[4'(23 - rises)]; // msb first on falling sclk
    if (adc_reset === 1'b1) begin
      run_len <= run_len + 1;
    end else if (run_len != 0) begin
      last_run <= run_len;
      run_len <= 0;
    end
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
      stop_run();
    end
  end

  a_ack_has_req: assert property (@(posedge OPB_Clk) disable iff (reset) ack |-> $past(req))
    else begin $display("ack raised without req at %0t", $time); stop_run(); end
  a_ack_drops: assert property (@(posedge OPB_Clk) disable iff (reset) $fell(req) |=> !ack)
    else begin $display("ERR %0t ack exp 0 got 1", $time); stop_run(); end
  a_frame_len: assert property (@(posedge OPB_Clk) disable iff (reset) rises <= 24)
    else begin $display("ERR %0t rises exp <=24 got %0d", $time, rises); stop_run(); end

  initial begin
    {reset, req, we, idx, wdata, dcm_locked, adc_sdata_in} = {1'b1, 37'h0, 1'b1, 1'b0};
    {sclk_q, mode_q, rd_mode, frame_bits, rd_value} = '0;
    {rises, frames_done, cycles, run_len, last_run} = '0;
    seed = 32'h1a31;
    repeat (4) @(posedge OPB_Clk);
    reset <= 1'b0;
    @(negedge OPB_Clk);
    check_val("ack", 0, 32'(ack));
    check_val("adc_sclk", 0, 32'(adc_sclk));
    check_val("adc_modepin", 1, 32'(adc_modepin));
    check_val("adc_spi_rst", 1, 32'(adc_spi_rst));
    n = 0;
    while (adc_reset) begin
      n++;
      @(negedge OPB_Clk);
    end
    check_val("adc_reset length", RST_LENGTH, n);
    host_access(1'b0, REG_CONFIG, 32'h0, rd_word);
    check_val("cfg done after reset", 1, 32'(rd_word[0]));

    // write frame
    seed = lcg_next(seed);
    addr = 8'h80 | seed[15:8];
    seed = lcg_next(seed);
    data = seed[23:8];
    host_access(1'b1, REG_CONFIG, {1'b1, 7'h0, addr, data}, rd_word);
    wait_done(rd_word);
    check_val("rises", 24, rises);
    check_val("frame_bits", 32'({addr, data}), 32'(frame_bits));
    check_val("rdata addr", 32'(addr), 32'(rd_word[15:8]));

    // read frame
    seed = lcg_next(seed);
    addr = {1'b0, seed[14:8]};
    seed = lcg_next(seed);
    rd_value = seed[23:8];
    host_access(1'b1, REG_CONFIG, {1'b1, 7'h0, addr, 16'h0}, rd_word);
    wait_done(rd_word);
    check_val("address bits", 32'(addr), 32'(frame_bits[23:16]));
    check_val("rdata read", 32'(rd_value), 32'(rd_word[31:16]));

    // second write stalls until the first frame ends
    host_access(1'b1, REG_CONFIG, {1'b1, 7'h0, 8'hc5, 16'h1234}, rd_word);
    frames_before = frames_done;
    host_access(1'b1, REG_CONFIG, {1'b1, 7'h0, 8'ha3, 16'h5a0f}, rd_word);
    check_val("frames before stalled ack", frames_before + 1, frames_done);
    wait_done(rd_word);
    check_val("frame_bits", 32'h00a35a0f, 32'(frame_bits));

    // dcm unlock and adc reset request
    seed = lcg_next(seed);
    low_cycles = 1 + int'(seed[12:8]);
    @(posedge OPB_Clk);
    dcm_locked <= 1'b0;
    repeat (low_cycles) @(posedge OPB_Clk);
    dcm_locked <= 1'b1;
    host_access(1'b1, REG_CTRL, 32'h1, rd_word);
    check_val("adc_reset start", 1, run_len); // high from the cycle after ack
    host_access(1'b0, REG_CTRL, 32'h0, rd_word);
    check_val("adc_reset flag", 1, 32'(rd_word[16]));
    check_val("unlock count", low_cycles, 32'(rd_word[15:0]));
    while (adc_reset) @(negedge OPB_Clk);
    @(negedge OPB_Clk);
    check_val("adc_reset request length", RST_LENGTH, last_run);

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
